// File: common/tankGamePkg.sv
`default_nettype none

package tankGamePkg;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Pixel coordinate as delivered by the display timer
    typedef logic [9:0] coordT;

    // Map cell indices, 20 columns and 15 rows
    typedef logic [4:0] cellIdxX;
    typedef logic [3:0] cellIdxY;

    // Cell type held in the map
    typedef logic [3:0] cellT;

    typedef struct packed {
        coordT x;
        coordT y;
    } pixelPosT;

    typedef struct packed {
        cellIdxX x;
        cellIdxY y;
    } cellAddrT;

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgbT;

    // Pad button levels
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
    } padT;

    typedef enum logic [1:0] {
        moverIdle,
        moverWrap,
        moverProbe,
        moverDecide
    } moverStateT;

    //////////////////////////////////////////////////////////////////////
    // Screen, cell and tank constants
    //////////////////////////////////////////////////////////////////////

    localparam coordT screenWidth  = 10'd640;
    localparam coordT screenHeight = 10'd480;

    // One cell covers 32 by 32 pixels
    localparam int cellShift = 5;
    localparam int mapCols   = 20;
    localparam int mapRows   = 15;

    // Tank box is inclusive, so it covers tankWidth plus one pixels
    localparam coordT tankWidth   = 10'd25;
    localparam coordT probeOffset = 10'd20;
    localparam coordT edgeWidth   = 10'd0;

    localparam rgbT tankColour    = 12'h0F0;
    localparam rgbT blankColour   = 12'h000;
    localparam rgbT outsideColour = 12'h222;

    //////////////////////////////////////////////////////////////////////
    // Map layout and colours
    //////////////////////////////////////////////////////////////////////

    // One hex digit per cell, leftmost digit is column 0
    // Border is type 0, walls type 2, open floor type 3
    localparam cellT [0:mapCols-1] mapTable [0:mapRows-1] = '{
        80'h0000_0000_0000_0000_0000,
        80'h0232_3223_2332_3223_2320,
        80'h0332_3333_2332_3333_2330,
        80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330,
        80'h0232_3223_2222_3223_2330,
        80'h0333_3333_3333_3333_3330,
        80'h0222_2232_2222_2322_2220,
        80'h0333_3333_3333_3333_3330,
        80'h0232_3223_2222_3223_2320,
        80'h0332_3333_2332_3333_2330,
        80'h0222_2223_2332_3222_2220,
        80'h0332_3333_2332_3333_2330,
        80'h0232_3223_2332_3223_2320,
        80'h0000_0000_0000_0000_0000
    };

    // Blue border, grey rock, red wall, yellow floor
    localparam rgbT cellColour [0:15] = '{
        0:       12'h00F,
        1:       12'h444,
        2:       12'hF00,
        3:       12'hFF0,
        default: 12'h888
    };

    // Pixel position to map cell, folded into the 20 by 15 map
    function automatic cellAddrT cellOf(input pixelPosT pos);
        cellAddrT addr;
        addr.x = cellIdxX'((pos.x >> cellShift) % mapCols);
        addr.y = cellIdxY'((pos.y >> cellShift) % mapRows);
        return addr;
    endfunction

endpackage

`default_nettype wire

// File: hw/mapStore.sv
`timescale 1ns/1ns
`default_nettype none

module mapStore (
    input  logic                  Master_Clock_In,
    input  tankGamePkg::cellAddrT memAddr,
    output tankGamePkg::cellT     cellData
);

    // Read-only copy of the arena layout
    tankGamePkg::cellT [0:tankGamePkg::mapCols-1] mapMem [0:tankGamePkg::mapRows-1];

    assign mapMem = tankGamePkg::mapTable;

    // Single read port, data one cycle after the address
    always_ff @(posedge Master_Clock_In)
    begin
        cellData <= mapMem[memAddr.y][memAddr.x];
    end

    // Both clients fold their coordinates, so the address never leaves the map
    addrInMap : assert property (
        @(posedge Master_Clock_In)
        (memAddr.x < tankGamePkg::mapCols) && (memAddr.y < tankGamePkg::mapRows)
    ) else $error("mapStore address out of map x=%0d y=%0d", memAddr.x, memAddr.y);

endmodule

`default_nettype wire

// File: hw/mapArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mapArbiter (
    input  logic                  renderReq,
    input  tankGamePkg::cellAddrT renderAddr,
    input  logic                  moverReq,
    input  tankGamePkg::cellAddrT moverAddr,
    output tankGamePkg::cellAddrT memAddr,
    output logic                  moverGrant
);

    // Fixed priority, the renderer owns every cycle it asks for
    // The mover only gets the port in blanking or out-of-range pixels
    always_comb
    begin
        if (renderReq)
        begin
            memAddr = renderAddr;
        end
        else
        begin
            memAddr = moverAddr;
        end
    end

    // Grant is a plain level, valid for this cycle only
    // Data for a granted address shows up on cellData next cycle
    always_comb
    begin
        moverGrant = moverReq && !renderReq;
    end

endmodule

`default_nettype wire

// File: tankMover/tankMover.sv
`timescale 1ns/1ns
`default_nettype none

module tankMover (
    input  logic                  Master_Clock_In,
    input  logic                  reset,
    input  logic                  frameEnd,
    input  tankGamePkg::padT      pad,
    input  tankGamePkg::cellT     cellData,
    input  logic                  moverGrant,
    output logic                  moverReq,
    output tankGamePkg::cellAddrT moverAddr,
    output tankGamePkg::pixelPosT tankPos
);

    tankGamePkg::moverStateT state;
    // Working copy during an update, tankPos only changes at the end
    tankGamePkg::pixelPosT   workPos;
    tankGamePkg::pixelPosT   wrapPos;
    tankGamePkg::pixelPosT   probePos;
    tankGamePkg::pixelPosT   nextPos;
    // Corner reads issued so far, bit 2 set once all four are out
    logic [2:0]              reqCount;
    logic                    pending;
    logic [1:0]              pendIdx;
    // Blocked corners: 0 bottom-left, 1 bottom-right, 2 top-left, 3 top-right
    logic [3:0]              blocked;
    logic                    cellBlocks;

    // Edge wrap along one axis
    function automatic tankGamePkg::coordT wrapAxis(
        input tankGamePkg::coordT pos,
        input tankGamePkg::coordT span
    );
        tankGamePkg::coordT result;
        result = pos;
        if (pos == tankGamePkg::edgeWidth)
            result = span - tankGamePkg::tankWidth;
        else if (pos == span - tankGamePkg::tankWidth - tankGamePkg::edgeWidth)
            result = '0;
        return result;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Corner probes
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        wrapPos.x = wrapAxis(tankPos.x, tankGamePkg::screenWidth);
        wrapPos.y = wrapAxis(tankPos.y, tankGamePkg::screenHeight);
    end

    // Corner index bit 0 picks the far column, bit 1 the far row
    always_comb
    begin
        probePos = workPos;
        if (reqCount[0])
            probePos.x = workPos.x + tankGamePkg::probeOffset;
        if (reqCount[1])
            probePos.y = workPos.y + tankGamePkg::probeOffset;
    end

    // Request and address stay put until the arbiter grants
    assign moverReq   = (state == tankGamePkg::moverProbe) && !reqCount[2];
    assign moverAddr  = tankGamePkg::cellOf(probePos);
    // Rock and wall cells stop the tank
    assign cellBlocks = (cellData == 4'd1) || (cellData == 4'd2);

    //////////////////////////////////////////////////////////////////////
    // Push-back or button move
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        nextPos = workPos;
        if (blocked[0] && blocked[1])
            nextPos.y = workPos.y - 10'd1;
        else if (blocked[0] && blocked[2])
            nextPos.x = workPos.x + 10'd1;
        else if (blocked[2] && blocked[3])
            nextPos.y = workPos.y + 10'd1;
        else if (blocked[1] && blocked[3])
            nextPos.x = workPos.x - 10'd1;
        else if (blocked[0])
        begin
            nextPos.y = workPos.y - 10'd1;
            nextPos.x = workPos.x + 10'd1;
        end
        else if (blocked[1])
        begin
            nextPos.y = workPos.y - 10'd1;
            nextPos.x = workPos.x - 10'd1;
        end
        else if (blocked[2])
        begin
            nextPos.y = workPos.y + 10'd1;
            nextPos.x = workPos.x + 10'd1;
        end
        else if (blocked[3])
        begin
            nextPos.y = workPos.y + 10'd1;
            nextPos.x = workPos.x - 10'd1;
        end
        // Free to drive, one button at a time
        else if (pad.up)
            nextPos.y = workPos.y - 10'd1;
        else if (pad.right)
            nextPos.x = workPos.x + 10'd1;
        else if (pad.down)
            nextPos.y = workPos.y + 10'd1;
        else if (pad.left)
            nextPos.x = workPos.x - 10'd1;
    end

    // Wrapped position enters the update
    always_ff @(posedge Master_Clock_In)
    begin
        if (state == tankGamePkg::moverWrap)
            workPos <= wrapPos;
    end

    always_ff @(posedge Master_Clock_In)
    begin
        if (reset)
        begin
            state    <= tankGamePkg::moverIdle;
            tankPos  <= '0;
            reqCount <= '0;
            pending  <= 1'b0;
            pendIdx  <= '0;
            blocked  <= '0;
        end
        else
        begin
            case (state)
                // Busy frames drop their frameEnd here
                tankGamePkg::moverIdle:
                begin
                    if (frameEnd)
                        state <= tankGamePkg::moverWrap;
                end
                tankGamePkg::moverWrap:
                begin
                    reqCount <= '0;
                    pending  <= 1'b0;
                    blocked  <= '0;
                    state    <= tankGamePkg::moverProbe;
                end
                tankGamePkg::moverProbe:
                begin
                    pending <= moverGrant;
                    if (moverGrant)
                    begin
                        reqCount <= reqCount + 3'd1;
                        pendIdx  <= reqCount[1:0];
                    end
                    // Read data lands one cycle after its grant
                    if (pending)
                    begin
                        blocked[pendIdx] <= cellBlocks;
                        if (pendIdx == 2'd3)
                            state <= tankGamePkg::moverDecide;
                    end
                end
                tankGamePkg::moverDecide:
                begin
                    tankPos <= nextPos;
                    state   <= tankGamePkg::moverIdle;
                end
                default:
                    state <= tankGamePkg::moverIdle;
            endcase
        end
    end

    // Request only falls after its last grant or on the way back to idle
    reqHeldToGrant : assert property (
        @(posedge Master_Clock_In) disable iff (reset)
        $fell(moverReq) |-> ($past(moverGrant) || state == tankGamePkg::moverIdle)
    ) else $error("tankMover dropped moverReq without a grant");

    // A stalled read keeps its address
    addrHeldToGrant : assert property (
        @(posedge Master_Clock_In) disable iff (reset)
        (moverReq && !moverGrant) |=> (moverReq && $stable(moverAddr))
    ) else $error("tankMover changed moverAddr while waiting");

endmodule

`default_nettype wire

// File: hw/pixelRenderer.sv
`timescale 1ns/1ns
`default_nettype none

module pixelRenderer (
    input  logic                  Master_Clock_In,
    input  logic                  reset,
    input  logic                  dispEna,
    input  tankGamePkg::pixelPosT pixel,
    input  tankGamePkg::pixelPosT tankPos,
    input  tankGamePkg::cellT     cellData,
    output logic                  renderReq,
    output tankGamePkg::cellAddrT renderAddr,
    output logic                  frameEnd,
    output tankGamePkg::rgbT      colour
);

    logic                  inRange;
    tankGamePkg::pixelPosT pixQ;
    logic                  enaQ;
    logic                  inRangeQ;
    logic                  inBox;
    tankGamePkg::rgbT      nextColour;

    //////////////////////////////////////////////////////////////////////
    // Stage 1
    //////////////////////////////////////////////////////////////////////

    // Visible window, edges included
    always_comb
    begin
        inRange = (pixel.x <= tankGamePkg::screenWidth) &&
                  (pixel.y <= tankGamePkg::screenHeight);
    end

    // Map read goes out with the pixel, data comes back with stage 1
    assign renderReq  = dispEna && inRange;
    assign renderAddr = tankGamePkg::cellOf(pixel);

    always_ff @(posedge Master_Clock_In)
    begin
        pixQ <= pixel;
    end

    always_ff @(posedge Master_Clock_In)
    begin
        if (reset)
        begin
            enaQ     <= 1'b0;
            inRangeQ <= 1'b0;
            frameEnd <= 1'b0;
            colour   <= tankGamePkg::blankColour;
        end
        else
        begin
            enaQ     <= dispEna;
            inRangeQ <= inRange;
            // Last visible coordinate kicks the tank update
            frameEnd <= dispEna &&
                        (pixel.x == tankGamePkg::screenWidth) &&
                        (pixel.y == tankGamePkg::screenHeight);
            colour   <= nextColour;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2
    //////////////////////////////////////////////////////////////////////

    // Inclusive tank box, 11 bits so the far edge cannot wrap
    always_comb
    begin
        inBox = ({1'b0, pixQ.x} >= {1'b0, tankPos.x}) &&
                ({1'b0, pixQ.x} <= {1'b0, tankPos.x} + {1'b0, tankGamePkg::tankWidth}) &&
                ({1'b0, pixQ.y} >= {1'b0, tankPos.y}) &&
                ({1'b0, pixQ.y} <= {1'b0, tankPos.y} + {1'b0, tankGamePkg::tankWidth});
    end

    always_comb
    begin
        if (!enaQ)
            nextColour = tankGamePkg::blankColour;
        else if (!inRangeQ)
            nextColour = tankGamePkg::outsideColour;
        else if (inBox)
            nextColour = tankGamePkg::tankColour;
        else
            nextColour = tankGamePkg::cellColour[cellData];  // flat colour per cell type
    end

    // Blanking reaches the output after exactly two edges
    blankAfterTwo : assert property (
        @(posedge Master_Clock_In) disable iff (reset)
        !dispEna |-> ##2 (colour == tankGamePkg::blankColour)
    ) else $error("pixelRenderer colour %h during blanking", colour);

endmodule

`default_nettype wire

// File: hw/tankArena.sv
`timescale 1ns/1ns
`default_nettype none

module tankArena (
    input  logic                  Master_Clock_In,
    input  logic                  reset,
    input  logic                  dispEna,
    input  tankGamePkg::pixelPosT pixel,
    input  tankGamePkg::padT      pad,
    output tankGamePkg::rgbT      colour
);

    // Map read clients
    logic                  renderReq;
    tankGamePkg::cellAddrT renderAddr;
    logic                  moverReq;
    tankGamePkg::cellAddrT moverAddr;
    logic                  moverGrant;

    // Shared read port
    tankGamePkg::cellAddrT memAddr;
    tankGamePkg::cellT     cellData;

    // Renderer to mover and back
    logic                  frameEnd;
    tankGamePkg::pixelPosT tankPos;

    pixelRenderer i_pixelRenderer (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset),
        .dispEna         (dispEna),
        .pixel           (pixel),
        .tankPos         (tankPos),
        .cellData        (cellData),
        .renderReq       (renderReq),
        .renderAddr      (renderAddr),
        .frameEnd        (frameEnd),
        .colour          (colour)
    );

    tankMover i_tankMover (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset),
        .frameEnd        (frameEnd),
        .pad             (pad),
        .cellData        (cellData),
        .moverGrant      (moverGrant),
        .moverReq        (moverReq),
        .moverAddr       (moverAddr),
        .tankPos         (tankPos)
    );

    mapArbiter i_mapArbiter (
        .renderReq       (renderReq),
        .renderAddr      (renderAddr),
        .moverReq        (moverReq),
        .moverAddr       (moverAddr),
        .memAddr         (memAddr),
        .moverGrant      (moverGrant)
    );

    mapStore i_mapStore (
        .Master_Clock_In (Master_Clock_In),
        .memAddr         (memAddr),
        .cellData        (cellData)
    );

endmodule

`default_nettype wire

// File: bench/tankArenaTb.sv
`timescale 1ns/1ns
`default_nettype none

module tankArenaTb;

    localparam int maxLines = 256;

    logic                  Master_Clock_In;
    logic                  reset;
    logic                  dispEna;
    tankGamePkg::pixelPosT pixel;
    tankGamePkg::padT      pad;
    tankGamePkg::rgbT      colour;

    // Command, test, x, y, argument
    logic [43:0] stimMem [0:maxLines-1];

    // Two pixels in flight between drive and colour
    logic             pipeCheck [0:1];
    tankGamePkg::rgbT pipeExp   [0:1];
    int               pipeX     [0:1];
    int               pipeY     [0:1];
    int               pipeTest  [0:1];

    // Reference tank, pending position waits for enough blanking
    int   modelX;
    int   modelY;
    int   pendX;
    int   pendY;
    logic modelPending;
    int   blankSeen;

    int   testChecks [0:15];
    int   testErrors [0:15];
    int   curTest;
    int   cycleLimit;
    logic limitReady = 1'b0;

    tankArena i_tankArena (
        .Master_Clock_In (Master_Clock_In),
        .reset           (reset),
        .dispEna         (dispEna),
        .pixel           (pixel),
        .pad             (pad),
        .colour          (colour)
    );

    always #5 Master_Clock_In = ~Master_Clock_In;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic tankGamePkg::cellT cellAt(input int x, input int y);
        int col;
        int row;
        col = (x / 32) % tankGamePkg::mapCols;
        row = (y / 32) % tankGamePkg::mapRows;
        return tankGamePkg::mapTable[row][col];
    endfunction

    function automatic logic blocksAt(input int x, input int y);
        tankGamePkg::cellT kind;
        kind = cellAt(x, y);
        return (kind == 4'd1) || (kind == 4'd2);
    endfunction

    function automatic tankGamePkg::rgbT expectColour(
        input int x, input int y, input int tx, input int ty
    );
        tankGamePkg::rgbT result;
        if (x > 640 || y > 480)
            result = tankGamePkg::outsideColour;
        else if (x >= tx && x <= tx + 25 && y >= ty && y <= ty + 25)
            result = tankGamePkg::tankColour;
        else
            result = tankGamePkg::cellColour[cellAt(x, y)];
        return result;
    endfunction

    // Edges flip to the far side and back
    function automatic int wrapCoord(input int p, input int span);
        if (p == 0)
            return span - 25;
        else if (p == span - 25)
            return 0;
        return p;
    endfunction

    task automatic planTankMove();
        int   wx;
        int   wy;
        int   fx;
        int   fy;
        logic b0;
        logic b1;
        logic b2;
        logic b3;
        wx = wrapCoord(modelX, 640);
        wy = wrapCoord(modelY, 480);
        fx = (wx + 20) % 1024;
        fy = (wy + 20) % 1024;
        // Probe order matches the mover, near corner first
        b0 = blocksAt(wx, wy);
        b1 = blocksAt(fx, wy);
        b2 = blocksAt(wx, fy);
        b3 = blocksAt(fx, fy);
        pendX = wx;
        pendY = wy;
        if (b0 && b1)
            pendY = wy - 1;
        else if (b0 && b2)
            pendX = wx + 1;
        else if (b2 && b3)
            pendY = wy + 1;
        else if (b1 && b3)
            pendX = wx - 1;
        else if (b0)
        begin
            pendY = wy - 1;
            pendX = wx + 1;
        end
        else if (b1)
        begin
            pendY = wy - 1;
            pendX = wx - 1;
        end
        else if (b2)
        begin
            pendY = wy + 1;
            pendX = wx + 1;
        end
        else if (b3)
        begin
            pendY = wy + 1;
            pendX = wx - 1;
        end
        else if (pad.up)
            pendY = wy - 1;
        else if (pad.right)
            pendX = wx + 1;
        else if (pad.down)
            pendY = wy + 1;
        else if (pad.left)
            pendX = wx - 1;
        pendX = (pendX + 1024) % 1024;
        pendY = (pendY + 1024) % 1024;
        modelPending = 1'b1;
        blankSeen = 0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Drive and check
    //////////////////////////////////////////////////////////////////////

    // Checks the pixel from two drives back, then drives the next one
    task automatic driveCycle(
        input logic ena, input int x, input int y,
        input logic check, input tankGamePkg::rgbT expected
    );
        @(negedge Master_Clock_In);
        if (pipeCheck[1])
        begin
            testChecks[pipeTest[1]]++;
            assert (colour === pipeExp[1])
            else
            begin
                $display("Fail colour at pixel (%0d,%0d): expected %h got %h",
                         pipeX[1], pipeY[1], pipeExp[1], colour);
                testErrors[pipeTest[1]]++;
            end
        end
        pipeCheck[1] = pipeCheck[0];
        pipeExp[1]   = pipeExp[0];
        pipeX[1]     = pipeX[0];
        pipeY[1]     = pipeY[0];
        pipeTest[1]  = pipeTest[0];
        pipeCheck[0] = check;
        pipeExp[0]   = expected;
        pipeX[0]     = x;
        pipeY[0]     = y;
        pipeTest[0]  = curTest;
        dispEna = ena;
        pixel.x = 10'(x);
        pixel.y = 10'(y);
        // Mover only gets the map when the renderer is quiet
        if (modelPending && (!ena || x > 640 || y > 480))
        begin
            blankSeen++;
            if (blankSeen >= 8)
            begin
                modelX = pendX;
                modelY = pendY;
                modelPending = 1'b0;
            end
        end
    endtask

    task automatic runBlank(input int count);
        repeat (count)
            driveCycle(1'b0, 0, 0, 1'b1, tankGamePkg::blankColour);
    endtask

    task automatic randomPixels(input int count);
        int x;
        int y;
        repeat (count)
        begin
            x = int'($urandom_range(639));
            y = int'($urandom_range(479));
            driveCycle(1'b1, x, y, 1'b1, expectColour(x, y, modelX, modelY));
        end
    endtask

    // Box corners and one step outside each edge
    task automatic boxCheck();
        int px [0:7];
        int py [0:7];
        int k;
        int x;
        int y;
        px[0] = modelX;
        py[0] = modelY;
        px[1] = modelX + 25;
        py[1] = modelY;
        px[2] = modelX;
        py[2] = modelY + 25;
        px[3] = modelX + 25;
        py[3] = modelY + 25;
        px[4] = modelX - 1;
        py[4] = modelY;
        px[5] = modelX + 26;
        py[5] = modelY;
        px[6] = modelX;
        py[6] = modelY - 1;
        px[7] = modelX;
        py[7] = modelY + 26;
        for (k = 0; k < 8; k++)
        begin
            x = (px[k] + 1024) % 1024;
            y = (py[k] + 1024) % 1024;
            // The last visible coordinate would start another update
            if (!(x == 640 && y == 480))
                driveCycle(1'b1, x, y, 1'b1, expectColour(x, y, modelX, modelY));
        end
    endtask

    // Tank stays put for many cycles after this pixel, so its colour is known
    task automatic frameEndPixel();
        driveCycle(1'b1, 640, 480, 1'b1, expectColour(640, 480, modelX, modelY));
        planTankMove();
    endtask

    task automatic reportTest(input int id);
        $display("Test %0d done: %0d checks, %0d errors", id, testChecks[id], testErrors[id]);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [43:0] word;
        int          cmd;
        int          testId;
        int          xf;
        int          yf;
        int          arg;
        int          idx;
        int          totalChecks;
        int          totalErrors;
        Master_Clock_In = 1'b0;
        reset        = 1'b1;
        dispEna      = 1'b0;
        pixel        = '0;
        pad          = '0;
        modelX       = 0;
        modelY       = 0;
        pendX        = 0;
        pendY        = 0;
        modelPending = 1'b0;
        blankSeen    = 0;
        curTest      = 1;
        for (idx = 0; idx < 2; idx++)
        begin
            pipeCheck[idx] = 1'b0;
            pipeExp[idx]   = '0;
            pipeX[idx]     = 0;
            pipeY[idx]     = 0;
            pipeTest[idx]  = 1;
        end
        for (idx = 0; idx < 16; idx++)
        begin
            testChecks[idx] = 0;
            testErrors[idx] = 0;
        end
        void'($urandom(32'h2d1d53a6));
        for (idx = 0; idx < maxLines; idx++)
            stimMem[idx] = '0;
        $readmemh("bench/arenaStimulus.txt", stimMem);

        // Watchdog budget from the length of every command
        cycleLimit = 500;
        for (idx = 0; idx < maxLines; idx++)
        begin
            word = stimMem[idx];
            cmd = int'(word[43:40]);
            xf  = int'(word[35:24]);
            yf  = int'(word[23:12]);
            arg = int'(word[11:0]);
            case (cmd)
                1, 2:    cycleLimit += 1;
                3:       cycleLimit += xf * (arg + 10);
                4:       cycleLimit += (arg == 0) ? 40 : arg;
                6:       cycleLimit += arg;
                7:       cycleLimit += 2 * xf + yf + 1;
                8, 9:    cycleLimit += 8;
                default: cycleLimit += 2;
            endcase
        end
        limitReady = 1'b1;

        repeat (2) @(posedge Master_Clock_In);
        @(negedge Master_Clock_In);
        reset = 1'b0;
        testChecks[1]++;
        assert (colour === tankGamePkg::blankColour)
        else
        begin
            $display("Fail colour after reset: expected %h got %h",
                     tankGamePkg::blankColour, colour);
            testErrors[1]++;
        end

        for (idx = 0; idx < maxLines; idx++)
        begin
            word   = stimMem[idx];
            cmd    = int'(word[43:40]);
            testId = int'(word[39:36]);
            xf     = int'(word[35:24]);
            yf     = int'(word[23:12]);
            arg    = int'(word[11:0]);
            if (cmd == 0)
                break;
            if (testId != curTest)
            begin
                runBlank(2);
                reportTest(curTest);
                curTest = testId;
            end
            case (cmd)
                1: driveCycle(1'b1, xf, yf, 1'b1, tankGamePkg::rgbT'(word[11:0]));
                2: driveCycle(1'b1, xf, yf, 1'b1, expectColour(xf, yf, modelX, modelY));
                3:
                begin
                    repeat (xf)
                    begin
                        frameEndPixel();
                        runBlank(arg);
                        boxCheck();
                    end
                end
                4: runBlank((arg == 0) ? 8 + int'($urandom_range(32)) : arg);
                5: pad = tankGamePkg::padT'(word[3:0]);
                6: randomPixels(arg);
                7:
                begin
                    // Update starts under a busy renderer and stalls
                    frameEndPixel();
                    randomPixels(xf);
                    runBlank(yf);
                    randomPixels(xf);
                end
                8: boxCheck();
                // Box edges where the push-back left the tank
                9: boxCheck();
                default:
                begin
                    $display("Unknown stimulus command %0d on line %0d", cmd, idx);
                    testErrors[curTest]++;
                end
            endcase
        end
        runBlank(2);
        reportTest(curTest);

        totalChecks = 0;
        totalErrors = 0;
        for (idx = 0; idx < 16; idx++)
        begin
            totalChecks += testChecks[idx];
            totalErrors += testErrors[idx];
        end
        $display("Checks %0d, errors %0d", totalChecks, totalErrors);
        if (totalErrors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // Ends a run that stopped making progress
    initial
    begin
        wait (limitReady);
        repeat (cycleLimit) @(posedge Master_Clock_In);
        $display("Watchdog expired after %0d cycles, stimulus did not complete", cycleLimit);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/arenaStimulus.txt
// cmd_test_xxx_yyy_arg in hex; 1 pixel with colour arg, 2 pixel from model, 3 xxx frames
// with arg blanking each, 4 blanking (0 random), 5 pad, 6 random pixels, 7 frame in visible run
// 8 box edges, 9 push-back seen, 0 end
4_1_000_000_000
1_1_281_00A_222
1_1_00A_1E1_222
1_1_2BC_258_222
1_1_064_064_F00
1_1_028_028_F00
1_1_046_028_FF0
1_1_005_0C8_00F
4_1_000_000_00A
2_1_1F4_0C8_000
6_2_000_000_040
4_2_000_000_000
6_2_000_000_040
4_2_000_000_010
3_3_001_000_00A
1_3_267_1C7_0F0
1_3_280_1C7_0F0
1_3_267_1E0_0F0
1_3_274_1D6_0F0
1_3_266_1C7_00F
1_3_267_1C6_00F
1_3_281_1D6_222
1_3_266_1E0_00F
4_3_000_000_000
5_4_000_000_004
3_4_00F_000_00A
6_4_000_000_020
5_5_000_000_002
3_5_00C_000_00A
9_5_000_000_000
6_5_000_000_020
7_6_01E_003_000
4_6_000_000_00C
8_6_000_000_000
6_6_000_000_020
4_6_000_000_000
0_0_000_000_000

// File: project.f
common/tankGamePkg.sv
hw/mapStore.sv
hw/mapArbiter.sv
tankMover/tankMover.sv
hw/pixelRenderer.sv
hw/tankArena.sv
bench/tankArenaTb.sv

// File: Makefile
OBJ = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tankArenaTb -f project.f

sim:
	verilator --binary --timing --assert --top-module tankArenaTb -Mdir $(OBJ) -f project.f
	./$(OBJ)/VtankArenaTb | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ)
